//--- source/pipePkg.sv
// shared types and constants for the integer pipeline
// imported by the RTL modules and by the testbench
`default_nettype none

package pipePkg;

	// APB byte addresses
	localparam logic [11:0] AddrInstr   = 12'h000;
	localparam logic [11:0] AddrStatus  = 12'h004;
	localparam logic [11:0] AddrCtrl    = 12'h008;
	// x0 to x31 live at 0x080 through 0x0FC
	localparam logic [11:0] AddrRegBase = 12'h080;

	// ALU operations, passB carries the LUI immediate through
	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluSll,
		AluSlt,
		AluSltu,
		AluXor,
		AluSrl,
		AluSra,
		AluOr,
		AluAnd,
		AluPassB
	} aluOpT;

	// raw instruction word as popped from the queue
	typedef logic [31:0] fetchT;

	// decode to execute record
	typedef struct packed {
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] rs1Val;
		logic [31:0] rs2Val;
		logic [31:0] imm;
		logic        useImm;
		aluOpT       aluOp;
		logic        writeEn;
	} decodedT;

	// execute to writeback record
	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] result;
		logic        writeEn;
	} wbT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apbReqT;

	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apbRspT;

endpackage

`default_nettype wire

//--- source/stageReg.sv
// valid-tagged pipeline register, one instance per stage boundary
// payload type is set per instance, hold freezes it, bubble loads an empty slot
`timescale 1ns/100ps
`default_nettype none

module stageReg #(
	parameter type payloadT = logic [31:0]
) (
	input  logic    clk,
	input  logic    reset,
	input  logic    hold,
	input  logic    bubble,
	input  logic    inValid,
	input  payloadT inData,
	output logic    outValid,
	output payloadT outData
);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			outValid <= 1'b0;
			outData  <= '0;
		end else if (!hold) begin
			// bubble wins over new data
			if (bubble) begin
				outValid <= 1'b0;
				outData  <= '0;
			end else begin
				outValid <= inValid;
				outData  <= inData;
			end
		end
	end

	// a live entry never carries unknown bits downstream
	dataKnown: assert property (@(posedge clk) disable iff (!reset)
		outValid |-> !$isunknown(outData));

endmodule

`default_nettype wire

//--- source/apbFrontEnd.sv
// APB slave of the pipeline, pushes instructions into the queue
// and serves status, control and register reads
`timescale 1ns/100ps
`default_nettype none

module apbFrontEnd #(
	parameter int QueueDepth = 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  pipePkg::apbReqT                 apbReq,
	output pipePkg::apbRspT                 apbRsp,
	output logic                            push,
	output pipePkg::fetchT                  pushData,
	input  logic                            queueFull,
	input  logic                            queueEmpty,
	input  logic [$clog2(QueueDepth+1)-1:0] queueLevel,
	input  logic                            pipeEmpty,
	input  logic                            retire,
	output logic                            run,
	output logic [4:0]                      dbgAddr,
	input  logic [31:0]                     dbgData
);
	import pipePkg::*;

	logic        access;
	logic        hitInstr;
	logic        hitStatus;
	logic        hitCtrl;
	logic        hitReg;
	logic        badAccess;
	logic        stall;
	logic [15:0] retiredCount;
	logic [7:0]  levelByte;
	logic [31:0] statusWord;
	logic [31:0] readData;

	// second cycle of a transfer
	assign access = apbReq.psel && apbReq.penable;

	// address decode
	assign hitInstr  = apbReq.paddr == AddrInstr;
	assign hitStatus = apbReq.paddr == AddrStatus;
	assign hitCtrl   = apbReq.paddr == AddrCtrl;
	// word aligned register window
	assign hitReg  = (apbReq.paddr[11:7] == AddrRegBase[11:7]) && (apbReq.paddr[1:0] == 2'b00);
	assign dbgAddr = apbReq.paddr[6:2];

	// only INSTR and CTRL take writes, only STATUS, CTRL and registers give reads
	always_comb begin
		if (apbReq.pwrite) begin
			badAccess = !(hitInstr || hitCtrl);
		end else begin
			badAccess = !(hitStatus || hitCtrl || hitReg);
		end
	end

	// instruction write waits for room in the queue
	assign stall    = apbReq.pwrite && hitInstr && queueFull;
	assign push     = access && apbReq.pwrite && hitInstr && !queueFull;
	assign pushData = apbReq.pwdata;

	assign levelByte  = 8'(queueLevel);
	assign statusWord = {retiredCount, levelByte, 6'b0, pipeEmpty, queueEmpty};

	always_comb begin
		readData = '0;
		if (hitStatus) begin
			readData = statusWord;
		end else if (hitCtrl) begin
			readData = {31'b0, run};
		end else if (hitReg) begin
			readData = dbgData;
		end
	end

	// zero wait states except for the stalled push
	always_comb begin
		apbRsp.pready  = access && !stall;
		apbRsp.pslverr = access && badAccess;
		apbRsp.prdata  = (access && !apbReq.pwrite && !badAccess) ? readData : '0;
	end

	// run bit and the wrapping retire counter
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			run          <= 1'b1;
			retiredCount <= '0;
		end else begin
			if (access && apbReq.pwrite && hitCtrl) begin
				run <= apbReq.pwdata[0];
			end
			if (retire) begin
				retiredCount <= retiredCount + 16'd1;
			end
		end
	end

	// a response shows up only after a setup cycle
	accessOnly: assert property (@(posedge clk) disable iff (!reset)
		(apbRsp.pready || apbRsp.pslverr) |-> access && $past(apbReq.psel));

endmodule

`default_nettype wire

//--- source/instrQueue.sv
// instruction FIFO between the APB front end and the pipeline
// head word is visible on popData, level counts stored entries
`timescale 1ns/100ps
`default_nettype none

module instrQueue #(
	parameter int QueueDepth = 8
) (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            push,
	input  pipePkg::fetchT                  pushData,
	input  logic                            pop,
	output pipePkg::fetchT                  popData,
	output logic                            full,
	output logic                            empty,
	output logic [$clog2(QueueDepth+1)-1:0] level
);
	import pipePkg::*;

	localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int LevelWidth = $clog2(QueueDepth + 1);

	fetchT                 mem [QueueDepth];
	logic [PtrWidth-1:0]   wrPtr;
	logic [PtrWidth-1:0]   rdPtr;
	logic [LevelWidth-1:0] count;

	// wrap at the depth, which need not be a power of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(QueueDepth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// storage
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			// simultaneous push and pop leave the level alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign popData = mem[rdPtr];
	assign full    = count == LevelWidth'(QueueDepth);
	assign empty   = count == '0;
	assign level   = count;

	// the front end and the pop logic in the top level respect the flags
	noOverflow: assert property (@(posedge clk) disable iff (!reset) push |-> !full);
	noUnderflow: assert property (@(posedge clk) disable iff (!reset) pop |-> !empty);

endmodule

`default_nettype wire

//--- source/regFile.sv
// 32 by 32 integer register file
// two decode read ports, one writeback port, one APB read port
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  rs1Addr,
	input  logic [4:0]  rs2Addr,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data,
	input  logic        wrEn,
	input  logic [4:0]  wrAddr,
	input  logic [31:0] wrData,
	input  logic [4:0]  dbgAddr,
	output logic [31:0] dbgData
);

	logic [31:0] regs [32];
	logic        wrLive;

	// x0 stays zero
	assign wrLive = wrEn && (wrAddr != 5'd0);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrLive) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write before read, decode sees the value retiring this cycle
	assign rs1Data = (wrLive && (wrAddr == rs1Addr)) ? wrData : regs[rs1Addr];
	assign rs2Data = (wrLive && (wrAddr == rs2Addr)) ? wrData : regs[rs2Addr];

	assign dbgData = regs[dbgAddr];

endmodule

`default_nettype wire

//--- source/decodeStage.sv
// decode of OP, OP-IMM and LUI with register read
// purely combinational, sits between instrStage and decStage
`timescale 1ns/100ps
`default_nettype none

module decodeStage (
	input  pipePkg::fetchT   instr,
	output logic [4:0]       rs1Addr,
	output logic [4:0]       rs2Addr,
	input  logic [31:0]      rs1Data,
	input  logic [31:0]      rs2Data,
	output pipePkg::decodedT decoded
);
	import pipePkg::*;

	localparam logic [6:0] OpcodeOp    = 7'b0110011;
	localparam logic [6:0] OpcodeOpImm = 7'b0010011;
	localparam logic [6:0] OpcodeLui   = 7'b0110111;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        altFunct;
	logic [31:0] immI;
	logic [31:0] immU;
	aluOpT       baseOp;

	// instruction fields
	assign opcode   = instr[6:0];
	assign funct3   = instr[14:12];
	// funct7 bit 5, also imm bit 10 for SRAI
	assign altFunct = instr[30];
	assign rs1Addr  = instr[19:15];
	assign rs2Addr  = instr[24:20];

	// sign-extended I-type, upper U-type
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immU = {instr[31:12], 12'b0};

	// funct3 to ALU op, shared by both arithmetic groups
	always_comb begin
		case (funct3)
			3'b000:  baseOp = AluAdd;
			3'b001:  baseOp = AluSll;
			3'b010:  baseOp = AluSlt;
			3'b011:  baseOp = AluSltu;
			3'b100:  baseOp = AluXor;
			3'b101:  baseOp = altFunct ? AluSra : AluSrl;
			3'b110:  baseOp = AluOr;
			default: baseOp = AluAnd;
		endcase
	end

	always_comb begin
		decoded.rd      = instr[11:7];
		decoded.rs1     = rs1Addr;
		decoded.rs2     = rs2Addr;
		decoded.rs1Val  = rs1Data;
		decoded.rs2Val  = rs2Data;
		decoded.imm     = immI;
		decoded.useImm  = 1'b0;
		decoded.aluOp   = baseOp;
		decoded.writeEn = 1'b0;
		case (opcode)
			OpcodeOp: begin
				// SUB only exists in the register form
				if ((funct3 == 3'b000) && altFunct) begin
					decoded.aluOp = AluSub;
				end
				decoded.writeEn = 1'b1;
			end
			OpcodeOpImm: begin
				decoded.useImm  = 1'b1;
				decoded.writeEn = 1'b1;
			end
			OpcodeLui: begin
				decoded.imm     = immU;
				decoded.useImm  = 1'b1;
				decoded.aluOp   = AluPassB;
				decoded.writeEn = 1'b1;
			end
			// anything else flows through as a no-op
			default: decoded.writeEn = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/executeStage.sv
// operand bypass from writeback and the ALU
// combinational, builds the record that wbStage captures
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input  pipePkg::decodedT decoded,
	input  logic             decValid,
	input  pipePkg::wbT      wbFwd,
	input  logic             wbValid,
	output pipePkg::wbT      result
);
	import pipePkg::*;

	logic        wbLive;
	logic        fwdA;
	logic        fwdB;
	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0]  shamt;
	logic [31:0] aluOut;

	// older result still in flight, x0 never forwards
	assign wbLive = wbValid && wbFwd.writeEn && (wbFwd.rd != 5'd0);
	assign fwdA   = wbLive && (wbFwd.rd == decoded.rs1);
	assign fwdB   = wbLive && (wbFwd.rd == decoded.rs2);

	assign opA = fwdA ? wbFwd.result : decoded.rs1Val;
	// immediate forms ignore rs2 entirely
	assign opB   = decoded.useImm ? decoded.imm : (fwdB ? wbFwd.result : decoded.rs2Val);
	assign shamt = opB[4:0];

	always_comb begin
		case (decoded.aluOp)
			AluAdd:   aluOut = opA + opB;
			AluSub:   aluOut = opA - opB;
			AluSll:   aluOut = opA << shamt;
			AluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
			AluSltu:  aluOut = {31'b0, opA < opB};
			AluXor:   aluOut = opA ^ opB;
			AluSrl:   aluOut = opA >> shamt;
			AluSra:   aluOut = $unsigned($signed(opA) >>> shamt);
			AluOr:    aluOut = opA | opB;
			AluAnd:   aluOut = opA & opB;
			AluPassB: aluOut = opB;
			default:  aluOut = '0;
		endcase
	end

	// an empty slot never asks for a write
	always_comb begin
		result.rd      = decoded.rd;
		result.result  = aluOut;
		result.writeEn = decoded.writeEn && decValid;
	end

endmodule

`default_nettype wire

//--- source/intPipeTop.sv
// top level of the four-stage integer pipeline behind an APB slave
// set QueueDepth here, it reaches the queue and the front end
`timescale 1ns/100ps
`default_nettype none

module intPipeTop #(
	parameter int QueueDepth = 8
) (
	input  logic            clk,
	input  logic            reset,
	input  pipePkg::apbReqT apbReq,
	output pipePkg::apbRspT apbRsp
);
	import pipePkg::*;

	localparam int LevelWidth = $clog2(QueueDepth + 1);

	logic                  push;
	logic                  pop;
	fetchT                 pushData;
	fetchT                 popData;
	logic                  queueFull;
	logic                  queueEmpty;
	logic [LevelWidth-1:0] queueLevel;
	logic                  run;
	logic                  hold;
	logic                  instrValid;
	fetchT                 instrWord;
	logic [4:0]            rs1Addr, rs2Addr;
	logic [31:0]           rs1Data, rs2Data;
	decodedT               decodedNext, decodedReg;
	logic                  decValid;
	wbT                    wbNext, wbReg;
	logic                  wbValid;
	logic                  pipeEmpty;
	logic                  retire;
	logic [4:0]            dbgAddr;
	logic [31:0]           dbgData;

	// the run bit stands in for the stage enable
	assign hold = !run;
	// pop matches the instrStage load, no bubble and no hold
	assign pop       = run && !queueEmpty;
	assign pipeEmpty = !(instrValid || decValid || wbValid);
	// counted once, on the edge where the entry leaves wbStage
	assign retire = run && wbValid;

	apbFrontEnd #(.QueueDepth(QueueDepth)) frontEnd0 (
		.clk(clk), .reset(reset), .apbReq(apbReq), .apbRsp(apbRsp),
		.push(push), .pushData(pushData), .queueFull(queueFull), .queueEmpty(queueEmpty),
		.queueLevel(queueLevel), .pipeEmpty(pipeEmpty), .retire(retire), .run(run),
		.dbgAddr(dbgAddr), .dbgData(dbgData));

	instrQueue #(.QueueDepth(QueueDepth)) queue0 (
		.clk(clk), .reset(reset), .push(push), .pushData(pushData), .pop(pop),
		.popData(popData), .full(queueFull), .empty(queueEmpty), .level(queueLevel));

	// empty queue inserts a bubble
	stageReg #(.payloadT(fetchT)) instrStage (
		.clk(clk), .reset(reset), .hold(hold), .bubble(queueEmpty), .inValid(1'b1),
		.inData(popData), .outValid(instrValid), .outData(instrWord));

	decodeStage decode0 (
		.instr(instrWord), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .decoded(decodedNext));

	stageReg #(.payloadT(decodedT)) decStage (
		.clk(clk), .reset(reset), .hold(hold), .bubble(1'b0), .inValid(instrValid),
		.inData(decodedNext), .outValid(decValid), .outData(decodedReg));

	executeStage execute0 (
		.decoded(decodedReg), .decValid(decValid), .wbFwd(wbReg), .wbValid(wbValid),
		.result(wbNext));

	stageReg #(.payloadT(wbT)) wbStage (
		.clk(clk), .reset(reset), .hold(hold), .bubble(1'b0), .inValid(decValid),
		.inData(wbNext), .outValid(wbValid), .outData(wbReg));

	// writeback port, also the APB read side
	regFile regs0 (
		.clk(clk), .reset(reset), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .wrEn(wbValid && wbReg.writeEn),
		.wrAddr(wbReg.rd), .wrData(wbReg.result), .dbgAddr(dbgAddr), .dbgData(dbgData));

endmodule

`default_nettype wire

//--- test/tbClock.sv
// clock and reset source for the pipeline testbench
// reset is held low for a few cycles and released on a falling edge
`timescale 1ns/100ps
`default_nettype none

module tbClock #(
	parameter int PeriodNs    = 20,
	parameter int ResetCycles = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PeriodNs / 2) clk = ~clk;
	end

	// release away from the rising edge
	initial begin
		reset = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
	end

endmodule

`default_nettype wire

//--- test/intPipeTb.sv
// testbench for the APB integer pipeline
// runs the directed stim file, then random ALU code and a back-pressure case against a model
`timescale 1ns/100ps
`default_nettype none

module intPipeTb;
	import pipePkg::*;

	localparam int          QueueDepth     = 8;
	localparam int          ApbWaitLimit   = 50;
	localparam int          IdleWaitLimit  = 100;
	localparam int          ResetWaitLimit = 20;
	localparam int          RandomCount    = 200;
	localparam int          BatchSize      = 8;
	localparam int          StallProbe     = 10;
	localparam int          SampleDelay    = 5;
	localparam logic [31:0] Seed           = 32'd94871;

	logic        clk;
	logic        reset;
	apbReqT      apbReq;
	apbRspT      apbRsp;
	logic [31:0] modelRegs [32];
	logic [15:0] modelRetired;
	logic [31:0] rngState;
	int          errorCount;
	int          checkCount;
	int          timeoutCount;

	tbClock #(.PeriodNs(20), .ResetCycles(2)) clock0 (.clk(clk), .reset(reset));

	intPipeTop #(.QueueDepth(QueueDepth)) dut0 (
		.clk(clk), .reset(reset), .apbReq(apbReq), .apbRsp(apbRsp));

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// address map rules for pslverr
	function automatic logic expectError(input logic write, input logic [11:0] addr);
		logic regWindow;
		regWindow = (addr >= AddrRegBase) && (addr <= 12'h0FC) && (addr[1:0] == 2'b00);
		if (write) begin
			return !((addr == AddrInstr) || (addr == AddrCtrl));
		end
		return !((addr == AddrStatus) || (addr == AddrCtrl) || regWindow);
	endfunction

	function automatic logic [31:0] statusExpect(input logic [15:0] retired,
			input logic [7:0] level, input logic pipeIdle, input logic queueIdle);
		return {retired, level, 6'b0, pipeIdle, queueIdle};
	endfunction

	// RV32I integer semantics
	function automatic logic [31:0] aluModel(input logic [2:0] funct3, input logic alt,
			input logic regForm, input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  sh;
		logic [31:0] value;
		sh = b[4:0];
		case (funct3)
			3'd0: value = (regForm && alt) ? a - b : a + b;
			3'd1: value = a << sh;
			3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: value = (a < b) ? 32'd1 : 32'd0;
			3'd4: value = a ^ b;
			3'd5: begin
				if (alt) begin
					value = $signed(a) >>> sh;
				end else begin
					value = a >> sh;
				end
			end
			3'd6: value = a | b;
			default: value = a & b;
		endcase
		return value;
	endfunction

	// random legal OP, OP-IMM or LUI word from two LCG draws
	function automatic logic [31:0] randomInstr(input logic [31:0] a, input logic [31:0] b);
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  funct3;
		logic        alt;
		logic [11:0] imm;
		logic [6:0]  funct7;
		logic [31:0] instr;
		rd     = a[31:27];
		rs1    = a[26:22];
		rs2    = a[21:17];
		funct3 = a[16:14];
		alt    = a[13];
		case (a[12:11])
			2'd0: instr = {b[31:12], rd, 7'b0110111};
			2'd1: begin
				imm = b[31:20];
				// shift immediates keep only shamt and the SRAI bit
				if (funct3 == 3'd1) begin
					imm = {7'b0, b[24:20]};
				end else if (funct3 == 3'd5) begin
					imm = {1'b0, alt, 5'b0, b[24:20]};
				end
				instr = {imm, rs1, funct3, rd, 7'b0010011};
			end
			default: begin
				funct7 = (alt && ((funct3 == 3'd0) || (funct3 == 3'd5))) ? 7'h20 : 7'h00;
				instr = {funct7, rs2, rs1, funct3, rd, 7'b0110011};
			end
		endcase
		return instr;
	endfunction

	task automatic drawInstr(output logic [31:0] instr);
		logic [31:0] a;
		logic [31:0] b;
		rngState = lcgNext(rngState);
		a = rngState;
		rngState = lcgNext(rngState);
		b = rngState;
		instr = randomInstr(a, b);
	endtask

	// every accepted push retires once, in push order
	task automatic modelExecute(input logic [31:0] instr);
		logic [4:0]  rd;
		logic [31:0] opA;
		logic [31:0] immI;
		logic [31:0] value;
		logic        writes;
		rd     = instr[11:7];
		opA    = modelRegs[instr[19:15]];
		immI   = {{20{instr[31]}}, instr[31:20]};
		writes = 1'b1;
		value  = '0;
		case (instr[6:0])
			7'b0110111: value = {instr[31:12], 12'b0};
			7'b0010011: value = aluModel(instr[14:12], instr[30], 1'b0, opA, immI);
			7'b0110011: begin
				value = aluModel(instr[14:12], instr[30], 1'b1, opA,
					modelRegs[instr[24:20]]);
			end
			default: writes = 1'b0;
		endcase
		if (writes && (rd != 5'd0)) begin
			modelRegs[rd] = value;
		end
		modelRetired = modelRetired + 16'd1;
	endtask

	task automatic noteTimeout(input string what);
		if (timeoutCount == 0) begin
			$display("timeout at %0d ns: %s", $time, what);
		end
		timeoutCount++;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] got);
		checkCount++;
		assert (got === expected) else begin
			errorCount++;
			$display("FAILED at %0d ns: %s expected 0x%08h got 0x%08h",
				$time, name, expected, got);
		end
	endtask

	task automatic checkError(input logic write, input logic [11:0] addr, input logic err);
		logic expected;
		expected = expectError(write, addr);
		checkCount++;
		assert (err === expected) else begin
			errorCount++;
			$display("FAILED at %0d ns: pslverr at 0x%03h expected %0b got %0b",
				$time, addr, expected, err);
		end
	endtask

	// one APB transfer with setup then access until pready or maxWait cycles
	task automatic apbTransfer(input logic write, input logic [11:0] addr,
			input logic [31:0] wdata, input int maxWait, output logic done,
			output logic [31:0] rdata, output logic err);
		int waited;
		done  = 1'b0;
		rdata = '0;
		err   = 1'b0;
		if (timeoutCount == 0) begin
			@(negedge clk);
			apbReq.psel    = 1'b1;
			apbReq.penable = 1'b0;
			apbReq.pwrite  = write;
			apbReq.paddr   = addr;
			apbReq.pwdata  = wdata;
			@(negedge clk);
			apbReq.penable = 1'b1;
			// sample mid cycle where the response is settled
			#(SampleDelay);
			waited = 0;
			while (!apbRsp.pready && (waited < maxWait)) begin
				@(negedge clk);
				#(SampleDelay);
				waited++;
			end
			done  = apbRsp.pready;
			rdata = apbRsp.prdata;
			err   = apbRsp.pslverr;
			if (done) begin
				@(posedge clk);
			end
			// back to idle, which withdraws an unfinished write
			@(negedge clk);
			apbReq.psel    = 1'b0;
			apbReq.penable = 1'b0;
		end
	endtask

	task automatic apbWrite(input logic [11:0] addr, input logic [31:0] data);
		logic        done;
		logic [31:0] rdata;
		logic        err;
		apbTransfer(1'b1, addr, data, ApbWaitLimit, done, rdata, err);
		if (done) begin
			checkError(1'b1, addr, err);
			if ((addr == AddrInstr) && !err) begin
				modelExecute(data);
			end
		end else if (timeoutCount == 0) begin
			noteTimeout($sformatf("pready never rose for a write to 0x%03h", addr));
		end
	endtask

	task automatic apbRead(input logic [11:0] addr, output logic [31:0] data, output logic ok);
		logic done;
		logic err;
		apbTransfer(1'b0, addr, '0, ApbWaitLimit, done, data, err);
		ok = done;
		if (done) begin
			checkError(1'b0, addr, err);
		end else if (timeoutCount == 0) begin
			noteTimeout($sformatf("pready never rose for a read of 0x%03h", addr));
		end
	endtask

	// data is only defined for a good read
	task automatic checkRead(input logic [11:0] addr, input logic [31:0] expected);
		logic [31:0] data;
		logic        ok;
		apbRead(addr, data, ok);
		if (ok && !expectError(1'b0, addr)) begin
			checkValue($sformatf("prdata at 0x%03h", addr), expected, data);
		end
	endtask

	// poll STATUS until queue and pipeline are both empty
	task automatic waitIdle();
		logic [31:0] status;
		logic        ok;
		int          polls;
		status = '0;
		ok     = 1'b1;
		polls  = 0;
		while (ok && (status[1:0] != 2'b11) && (polls < IdleWaitLimit)) begin
			apbRead(AddrStatus, status, ok);
			polls++;
		end
		if (ok && (status[1:0] != 2'b11)) begin
			noteTimeout("the queue and pipeline never drained");
		end
	endtask

	task automatic checkAllRegs();
		for (int i = 0; i < 32; i++) begin
			checkRead(AddrRegBase + 12'(i * 4), modelRegs[i]);
		end
	endtask

	task automatic runStimFile();
		int          fd;
		int          fields;
		string       line;
		byte         kind;
		logic [31:0] addrWord;
		logic [31:0] value;
		fd = $fopen("test/pipeStim.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("could not open the stimulus file test/pipeStim.txt");
		end else begin
			while (!$feof(fd)) begin
				line   = "";
				fields = $fgets(line, fd);
				if ((fields != 0) && (line.getc(0) != "#") && (line.getc(0) != "\n")) begin
					addrWord = '0;
					value    = '0;
					fields   = $sscanf(line, "%c %h %h", kind, addrWord, value);
					if ((kind == "W") && (fields == 3)) begin
						apbWrite(addrWord[11:0], value);
					end else if ((kind == "R") && (fields == 3)) begin
						checkRead(addrWord[11:0], value);
					end else if (kind == "I") begin
						waitIdle();
					end else begin
						errorCount++;
						$display("malformed line in the stimulus file: %s", line);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// random code in frozen batches that each drain back to back through the bypass
	task automatic runRandom();
		logic [31:0] instr;
		for (int n = 0; n < RandomCount; n++) begin
			if ((n % BatchSize) == 0) begin
				apbWrite(AddrCtrl, 32'd0);
			end
			drawInstr(instr);
			apbWrite(AddrInstr, instr);
			if ((n % BatchSize) == (BatchSize - 1)) begin
				apbWrite(AddrCtrl, 32'd1);
				waitIdle();
			end
		end
		apbWrite(AddrCtrl, 32'd1);
		waitIdle();
		checkAllRegs();
		checkRead(AddrStatus, statusExpect(modelRetired, 8'd0, 1'b1, 1'b1));
	endtask

	task automatic runBackPressure();
		logic        done;
		logic [31:0] rdata;
		logic        err;
		logic [31:0] instr;
		logic [31:0] held [2];
		logic [31:0] frozenStatus;
		logic [15:0] retiredBefore;
		// nothing retires while frozen
		retiredBefore = modelRetired;
		apbWrite(AddrCtrl, 32'd0);
		for (int n = 0; n < QueueDepth; n++) begin
			drawInstr(instr);
			apbWrite(AddrInstr, instr);
		end
		frozenStatus = statusExpect(retiredBefore, 8'(QueueDepth), 1'b1, 1'b0);
		checkRead(AddrStatus, frozenStatus);
		// the queue is full so these must stall
		for (int n = 0; n < 2; n++) begin
			drawInstr(held[n]);
			apbTransfer(1'b1, AddrInstr, held[n], StallProbe, done, rdata, err);
			checkCount++;
			assert (!done) else begin
				errorCount++;
				$display("a write to INSTR completed into a full queue while run was clear");
			end
		end
		checkRead(AddrStatus, frozenStatus);
		apbWrite(AddrCtrl, 32'd1);
		for (int n = 0; n < 2; n++) begin
			apbWrite(AddrInstr, held[n]);
		end
		waitIdle();
		checkAllRegs();
		checkRead(AddrStatus, statusExpect(modelRetired, 8'd0, 1'b1, 1'b1));
	endtask

	initial begin
		int waited;
		apbReq       = '0;
		errorCount   = 0;
		checkCount   = 0;
		timeoutCount = 0;
		modelRetired = '0;
		rngState     = Seed;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		waited = 0;
		while ((reset !== 1'b1) && (waited < ResetWaitLimit)) begin
			@(negedge clk);
			waited++;
		end
		if (reset !== 1'b1) begin
			noteTimeout("reset was never released");
		end
		// every register reads zero after reset
		checkAllRegs();
		runStimFile();
		runRandom();
		runBackPressure();
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
		if ((errorCount == 0) && (timeoutCount == 0)) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/pipePkg.sv
source/stageReg.sv
source/apbFrontEnd.sv
source/instrQueue.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/intPipeTop.sv
test/tbClock.sv
test/intPipeTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module intPipeTb -o intPipeSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/intPipeSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
	exit 0
fi
exit 1

//--- test/pipeStim.txt
# kind addr data: W is an APB write, R an APB read with expected data, I waits for idle
# hex fields: INSTR 000, STATUS 004, CTRL 008, x0 to x31 at 080 to 0FC
R 004 00000003
R 008 00000001
# frozen dependent chain drains back to back
W 008 00000000
W 000 123450B7
W 000 67808093
W 000 00108133
W 000 401101B3
W 000 FFF1C213
W 000 40425293
W 000 00425313
W 000 0032A3B3
W 008 00000001
W 000 0032B433
I
R 084 12345678
R 088 2468ACF0
R 08C 12345678
R 090 EDCBA987
R 094 FEDCBA98
R 098 0EDCBA98
R 09C 00000001
R 0A0 00000000
R 004 00090003
# x0 targets and illegal opcodes
W 000 00508013
W 000 FFFFF037
W 000 FFFFFFFF
W 000 002080E3
W 000 0000000B
I
R 080 00000000
R 084 12345678
R 0FC 00000000
R 004 000E0003
# APB errors leave the state alone
W 004 FFFFFFFF
W 084 DEADBEEF
R 010 00000000
R 000 00000000
R 004 000E0003
R 084 12345678
R 008 00000001
